/* src/mmu_pkg.sv */
//------------------------------
// sv39 data mmu constants and types, 32-bit physical space only
// commit word bit 8 is reserved and ignored by the hardware
//------------------------------
package mmu_pkg;

  // ------------------------------
  // address geometry
  // ------------------------------
  // sv39 virtual address, upper bits 63:39 are not checked
  localparam int unsigned va_w  = 39;
  localparam int unsigned vpn_w = 27;
  // ppn trimmed so that ppn + offset fills the 32-bit physical space
  localparam int unsigned ppn_w = 20;
  localparam int unsigned pa_w  = 32;
  localparam int unsigned off_w = 12;
  // vpn bits per page table level
  localparam int unsigned lvl_w = 9;

  // tlb size
  localparam int unsigned tlb_entries = 4;
  localparam int unsigned idx_w       = 2;

  // ------------------------------
  // apb register map
  // ------------------------------
  localparam int unsigned apb_aw = 4;
  localparam int unsigned apb_dw = 32;

  // staged vpn, bits 26:0
  localparam logic [apb_aw-1:0] reg_vpn_lo = 4'h0;
  // staged ppn
  localparam logic [apb_aw-1:0] reg_ppn    = 4'h4;
  // index and flags, writes the staged entry
  localparam logic [apb_aw-1:0] reg_commit = 4'h8;
  // any write invalidates every entry
  localparam logic [apb_aw-1:0] reg_flush  = 4'hC;

  // commit word layout, index sits in bits 1:0
  localparam int unsigned cmt_r_bit    = 4;
  localparam int unsigned cmt_w_bit    = 5;
  localparam int unsigned cmt_d_bit    = 6;
  localparam int unsigned cmt_u_bit    = 7;
  localparam int unsigned cmt_size_lsb = 9;

  // ------------------------------
  // types
  // ------------------------------
  typedef enum logic [1:0] {
    PAGE_4K = 2'd0,
    PAGE_2M = 2'd1,
    PAGE_1G = 2'd2
  } page_size_e;

  // only the two modes that can issue translated loads and stores
  typedef enum logic {
    PRIV_U = 1'b0,
    PRIV_S = 1'b1
  } priv_e;

  typedef enum logic [1:0] {
    EXC_NONE     = 2'd0,
    EXC_TLB_MISS = 2'd1,
    EXC_LOAD_PF  = 2'd2,
    EXC_STORE_PF = 2'd3
  } xlate_exc_e;

endpackage

/* src/tlb_apb_regs.sv */
//------------------------------
// apb slave without wait states
// commit and flush act on the access-phase edge
// unmapped offsets answer with pslverr and change nothing
//------------------------------
`timescale 1ns/10ps

module tlb_apb_regs
  import mmu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [apb_aw-1:0] paddr_i,
  input  logic [apb_dw-1:0] pwdata_i,
  output logic [apb_dw-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  output logic              wr_en_o,
  output logic [idx_w-1:0]  wr_idx_o,
  output logic [vpn_w-1:0]  wr_vpn_o,
  output logic [ppn_w-1:0]  wr_ppn_o,
  output logic              wr_r_o,
  output logic              wr_w_o,
  output logic              wr_d_o,
  output logic              wr_u_o,
  output page_size_e        wr_size_o,
  output logic              flush_o
);

  logic             access;
  logic             wr_access;
  logic             addr_ok;
  logic [vpn_w-1:0] vpn_q;
  logic [ppn_w-1:0] ppn_q;

  // access phase of a transfer
  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i & addr_ok;
  assign addr_ok   = paddr_i inside {reg_vpn_lo, reg_ppn, reg_commit, reg_flush};

  // no wait states so every access phase completes
  assign pready_o  = access;
  assign pslverr_o = access & ~addr_ok;

  // commit and flush read as zero
  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i) begin
      case (paddr_i)
        reg_vpn_lo: prdata_o = apb_dw'(vpn_q);
        reg_ppn:    prdata_o = apb_dw'(ppn_q);
        default:    prdata_o = '0;
      endcase
    end
  end

  // staged vpn and ppn for the next commit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vpn_q <= '0;
      ppn_q <= '0;
    end else if (wr_access) begin
      if (paddr_i == reg_vpn_lo) begin
        vpn_q <= pwdata_i[vpn_w-1:0];
      end
      if (paddr_i == reg_ppn) begin
        ppn_q <= pwdata_i[ppn_w-1:0];
      end
    end
  end

  // ------------------------------
  // tlb write strobe
  // ------------------------------
  // one cycle wide and captured by the tlb on the access-phase edge
  assign wr_en_o   = wr_access & (paddr_i == reg_commit);
  assign flush_o   = wr_access & (paddr_i == reg_flush);
  assign wr_idx_o  = pwdata_i[idx_w-1:0];
  assign wr_vpn_o  = vpn_q;
  assign wr_ppn_o  = ppn_q;
  assign wr_r_o    = pwdata_i[cmt_r_bit];
  assign wr_w_o    = pwdata_i[cmt_w_bit];
  assign wr_d_o    = pwdata_i[cmt_d_bit];
  assign wr_u_o    = pwdata_i[cmt_u_bit];
  assign wr_size_o = page_size_e'(pwdata_i[cmt_size_lsb +: 2]);

  // master must hold psel through the access phase
  a_penable_in_psel : assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i)
    else $error("tlb_apb_regs: penable high without psel");

endmodule

/* src/tlb_lookup.sv */
//------------------------------
// fully associative sv39 data tlb, no asid tagging
// software keeps vpns unique, two matching entries are illegal
//------------------------------
`timescale 1ns/10ps

module tlb_lookup
  import mmu_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  // entry write port
  input  logic             wr_en_i,
  input  logic [idx_w-1:0] wr_idx_i,
  input  logic [vpn_w-1:0] wr_vpn_i,
  input  logic [ppn_w-1:0] wr_ppn_i,
  input  logic             wr_r_i,
  input  logic             wr_w_i,
  input  logic             wr_d_i,
  input  logic             wr_u_i,
  input  page_size_e       wr_size_i,
  input  logic             flush_i,
  // request
  input  logic             req_i,
  input  logic [va_w-1:0]  vaddr_i,
  input  logic             is_store_i,
  input  priv_e            priv_i,
  input  logic             sum_i,
  input  logic             en_translation_i,
  // stage 0 registers
  output logic             s0_valid_o,
  output logic [va_w-1:0]  s0_vaddr_o,
  output logic             s0_store_o,
  output priv_e            s0_priv_o,
  output logic             s0_sum_o,
  output logic             s0_en_o,
  output logic             s0_hit_o,
  output logic [ppn_w-1:0] s0_ppn_o,
  output logic             s0_r_o,
  output logic             s0_w_o,
  output logic             s0_d_o,
  output logic             s0_u_o,
  output page_size_e       s0_size_o
);

  logic [tlb_entries-1:0] valid_q;
  logic [vpn_w-1:0]       vpn_q [tlb_entries];
  logic [ppn_w-1:0]       ppn_q [tlb_entries];
  page_size_e             size_q [tlb_entries];
  logic [tlb_entries-1:0] r_q;
  logic [tlb_entries-1:0] w_q;
  logic [tlb_entries-1:0] d_q;
  logic [tlb_entries-1:0] u_q;
  logic [vpn_w-1:0]       req_vpn;
  logic [tlb_entries-1:0] match;
  logic                   hit;
  logic [idx_w-1:0]       hit_idx;

  // ------------------------------
  // entry storage
  // ------------------------------
  // flush wins, though apb never issues both in one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_idx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      vpn_q[wr_idx_i]  <= wr_vpn_i;
      ppn_q[wr_idx_i]  <= wr_ppn_i;
      size_q[wr_idx_i] <= wr_size_i;
      r_q[wr_idx_i]    <= wr_r_i;
      w_q[wr_idx_i]    <= wr_w_i;
      d_q[wr_idx_i]    <= wr_d_i;
      u_q[wr_idx_i]    <= wr_u_i;
    end
  end

  // ------------------------------
  // associative match
  // ------------------------------
  assign req_vpn = vaddr_i[off_w +: vpn_w];

  always_comb begin
    match   = '0;
    hit_idx = '0;
    for (int i = 0; i < tlb_entries; i++) begin
      // vpn[2] always takes part
      match[i] = valid_q[i] && (vpn_q[i][2*lvl_w +: lvl_w] == req_vpn[2*lvl_w +: lvl_w]);
      // vpn[1] ignored for giga pages
      if (size_q[i] != PAGE_1G) begin
        match[i] = match[i] && (vpn_q[i][lvl_w +: lvl_w] == req_vpn[lvl_w +: lvl_w]);
      end
      // vpn[0] only for 4k pages
      if (size_q[i] == PAGE_4K) begin
        match[i] = match[i] && (vpn_q[i][lvl_w-1:0] == req_vpn[lvl_w-1:0]);
      end
      if (match[i]) begin
        hit_idx = idx_w'(i);
      end
    end
  end

  assign hit = |match;

  // ------------------------------
  // stage 0 registers
  // ------------------------------
  // en and hit qualified by req, an idle slot reads as untranslated
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s0_valid_o <= 1'b0;
      s0_en_o    <= 1'b0;
      s0_hit_o   <= 1'b0;
    end else begin
      s0_valid_o <= req_i;
      s0_en_o    <= req_i & en_translation_i;
      s0_hit_o   <= req_i & hit;
    end
  end

  // request payload and matching entry, only meaningful with s0_hit
  always_ff @(posedge clk_i) begin
    s0_vaddr_o <= vaddr_i;
    s0_store_o <= is_store_i;
    s0_priv_o  <= priv_i;
    s0_sum_o   <= sum_i;
    s0_ppn_o   <= ppn_q[hit_idx];
    s0_r_o     <= r_q[hit_idx];
    s0_w_o     <= w_q[hit_idx];
    s0_d_o     <= d_q[hit_idx];
    s0_u_o     <= u_q[hit_idx];
    s0_size_o  <= size_q[hit_idx];
  end

  // aliasing entries would make the selected ppn ambiguous
  a_match_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> $onehot0(match))
    else $error("tlb_lookup: more than one entry matches");

endmodule

/* src/xlate_check.sv */
//------------------------------
// stage 1, purely combinational from the stage 0 registers
// no pmp or access-fault checks, page faults and misses only
//------------------------------
`timescale 1ns/10ps

module xlate_check
  import mmu_pkg::*;
(
  input  logic             s0_valid_i,
  input  logic [va_w-1:0]  s0_vaddr_i,
  input  logic             s0_store_i,
  input  priv_e            s0_priv_i,
  input  logic             s0_sum_i,
  input  logic             s0_en_i,
  input  logic             s0_hit_i,
  input  logic [ppn_w-1:0] s0_ppn_i,
  input  logic             s0_r_i,
  input  logic             s0_w_i,
  input  logic             s0_d_i,
  input  logic             s0_u_i,
  input  page_size_e       s0_size_i,
  output logic             valid_o,
  output logic [pa_w-1:0]  paddr_o,
  output xlate_exc_e       exc_o
);

  logic [ppn_w-1:0] ppn_eff;
  logic             priv_err;
  logic             perm_err;

  assign valid_o = s0_valid_i;

  // ------------------------------
  // superpage substitution
  // ------------------------------
  // low ppn levels come from the vpn for mega and giga pages
  always_comb begin
    ppn_eff = s0_ppn_i;
    case (s0_size_i)
      PAGE_2M: ppn_eff[lvl_w-1:0]   = s0_vaddr_i[off_w +: lvl_w];
      PAGE_1G: ppn_eff[2*lvl_w-1:0] = s0_vaddr_i[off_w +: 2*lvl_w];
      default: ppn_eff = s0_ppn_i;
    endcase
  end

  // ------------------------------
  // access rights
  // ------------------------------
  // s mode may touch user pages only with sum, u mode only user pages
  assign priv_err = ((s0_priv_i == PRIV_S) && s0_u_i && !s0_sum_i) ||
                    ((s0_priv_i == PRIV_U) && !s0_u_i);
  // stores also need d set, no hardware dirty update here
  assign perm_err = s0_store_i ? (!s0_w_i || !s0_d_i) : !s0_r_i;

  always_comb begin
    // bare mode passthrough
    paddr_o = s0_vaddr_i[pa_w-1:0];
    exc_o   = EXC_NONE;
    if (s0_en_i) begin
      if (!s0_hit_i) begin
        // miss, software refills through apb
        paddr_o = '0;
        exc_o   = EXC_TLB_MISS;
      end else begin
        paddr_o = {ppn_eff, s0_vaddr_i[off_w-1:0]};
        if (priv_err || perm_err) begin
          exc_o = s0_store_i ? EXC_STORE_PF : EXC_LOAD_PF;
        end
      end
    end
  end

  // relies on tlb_lookup clearing s0_en for idle slots
  a_exc_needs_valid : assert final (valid_o || (exc_o == EXC_NONE))
    else $error("xlate_check: exception without a valid result");

endmodule

/* src/dmmu_top.sv */
//------------------------------
// sv39 data mmu, one result per request one cycle later
// no back-pressure, tlb filled by software over apb
//------------------------------
`timescale 1ns/10ps

module dmmu_top
  import mmu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // apb slave
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [apb_aw-1:0] paddr_i,
  input  logic [apb_dw-1:0] pwdata_i,
  output logic [apb_dw-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // lookup port
  input  logic              req_i,
  input  logic [va_w-1:0]   vaddr_i,
  input  logic              is_store_i,
  input  priv_e             priv_i,
  input  logic              sum_i,
  input  logic              en_translation_i,
  output logic              valid_o,
  output logic [pa_w-1:0]   paddr_o,
  output xlate_exc_e        exc_o
);

  // tlb write port
  logic             wr_en, wr_r, wr_w, wr_d, wr_u, flush;
  logic [idx_w-1:0] wr_idx;
  logic [vpn_w-1:0] wr_vpn;
  logic [ppn_w-1:0] wr_ppn;
  page_size_e       wr_size;

  // stage 0 to stage 1
  logic             s0_valid, s0_store, s0_sum, s0_en, s0_hit;
  logic             s0_r, s0_w, s0_d, s0_u;
  logic [va_w-1:0]  s0_vaddr;
  logic [ppn_w-1:0] s0_ppn;
  priv_e            s0_priv;
  page_size_e       s0_size;

  tlb_apb_regs i_regs (
    .clk_i, .rst_ni,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .wr_en_o (wr_en), .wr_idx_o (wr_idx), .wr_vpn_o (wr_vpn), .wr_ppn_o (wr_ppn),
    .wr_r_o  (wr_r),  .wr_w_o   (wr_w),   .wr_d_o   (wr_d),   .wr_u_o   (wr_u),
    .wr_size_o (wr_size),
    .flush_o   (flush)
  );

  tlb_lookup i_lookup (
    .clk_i, .rst_ni,
    .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_vpn_i (wr_vpn), .wr_ppn_i (wr_ppn),
    .wr_r_i  (wr_r),  .wr_w_i   (wr_w),   .wr_d_i   (wr_d),   .wr_u_i   (wr_u),
    .wr_size_i (wr_size),
    .flush_i   (flush),
    .req_i, .vaddr_i, .is_store_i, .priv_i, .sum_i, .en_translation_i,
    .s0_valid_o (s0_valid), .s0_vaddr_o (s0_vaddr), .s0_store_o (s0_store),
    .s0_priv_o  (s0_priv),  .s0_sum_o   (s0_sum),   .s0_en_o    (s0_en),
    .s0_hit_o   (s0_hit),   .s0_ppn_o   (s0_ppn),   .s0_size_o  (s0_size),
    .s0_r_o (s0_r), .s0_w_o (s0_w), .s0_d_o (s0_d), .s0_u_o (s0_u)
  );

  xlate_check i_check (
    .s0_valid_i (s0_valid), .s0_vaddr_i (s0_vaddr), .s0_store_i (s0_store),
    .s0_priv_i  (s0_priv),  .s0_sum_i   (s0_sum),   .s0_en_i    (s0_en),
    .s0_hit_i   (s0_hit),   .s0_ppn_i   (s0_ppn),   .s0_size_i  (s0_size),
    .s0_r_i (s0_r), .s0_w_i (s0_w), .s0_d_i (s0_d), .s0_u_i (s0_u),
    .valid_o, .paddr_o, .exc_o
  );

endmodule

/* bench/tb_clock_gen.sv */
//------------------------------
// testbench clock and reset, 40 ns period
// reset held low for the first 3 rising edges
//------------------------------
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // half period of 20 ns
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* bench/tb_dmmu.sv */
//------------------------------
// runs the vectors in bench/dmmu_testdata.txt against dmmu_top
// inputs change on the falling edge, results are sampled there too
//------------------------------
`timescale 1ns/10ps

module tb_dmmu
  import mmu_pkg::*;
;

  logic              clk, rst_n;
  logic              psel, penable, pwrite;
  logic [apb_aw-1:0] paddr;
  logic [apb_dw-1:0] pwdata, prdata;
  logic              pready, pslverr;
  logic              req, is_store, sum, en_xlate;
  logic [va_w-1:0]   vaddr;
  priv_e             priv;
  logic              valid;
  logic [pa_w-1:0]   paddr_out;
  xlate_exc_e        exc;

  // records, counters and the cycle limit
  string       recs[$];
  int          n_run, n_pass, n_fail;
  int          cycle_cnt, cycle_limit;
  // expected lookup results, one per request in flight
  logic        q_valid[$];
  logic [31:0] q_paddr[$];
  logic [1:0]  q_exc[$];
  int          q_id[$];

  tb_clock_gen i_clk (.clk_o (clk), .rst_no (rst_n));

  dmmu_top i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .paddr_i (paddr), .pwdata_i (pwdata),
    .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .req_i (req), .vaddr_i (vaddr), .is_store_i (is_store), .priv_i (priv),
    .sum_i (sum), .en_translation_i (en_xlate),
    .valid_o (valid), .paddr_o (paddr_out), .exc_o (exc)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, inout bit ok);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      ok = 0;
    end
  endtask

  task automatic finish_test(input int id, input string what, input bit ok);
    n_run++;
    if (ok) n_pass++;
    else n_fail++;
    $display("test %0d (%s): %s", id, what, ok ? "ok" : "error");
  endtask

  // result of the request driven on the previous falling edge
  task automatic check_pending();
    bit          ok;
    int          id;
    logic        ev;
    logic [31:0] ep;
    logic [1:0]  ee;
    ok = 1;
    id = q_id.pop_front();
    ev = q_valid.pop_front();
    ep = q_paddr.pop_front();
    ee = q_exc.pop_front();
    check_value("valid_o", 32'(valid), 32'(ev), ok);
    check_value("exc_o", 32'(exc), 32'(ee), ok);
    // paddr carries no meaning on an idle slot
    if (ev) check_value("paddr_o", paddr_out, ep, ok);
    finish_test(id, "lookup", ok);
  endtask

  // drains the pipe and parks the lookup port
  task automatic drain_lookups();
    if (q_id.size() > 0) begin
      @(negedge clk);
      check_pending();
      req = 1'b0;
    end
  endtask

  // setup then access phase, outputs sampled before the bus is released
  task automatic apb_transfer(input int id, input logic wr, input logic [3:0] addr,
                              input logic [31:0] data, input logic exp_err);
    bit ok;
    ok = 1;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wr ? data : '0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    check_value("pready_o", 32'(pready), 32'd1, ok);
    check_value("pslverr_o", 32'(pslverr), 32'(exp_err), ok);
    if (!wr) check_value("prdata_o", prdata, data, ok);
    psel    = 1'b0;
    penable = 1'b0;
    finish_test(id, wr ? "apb write" : "apb read", ok);
  endtask

  // ------------------------------
  // timeout
  // ------------------------------
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run took more than %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int          fd, cnt;
    string       line, op;
    logic        f_req, f_en, f_store, f_priv, f_sum, e_valid, e_err;
    logic [va_w-1:0] f_vaddr;
    logic [31:0] f_addr, f_data, e_paddr;
    logic [1:0]  e_exc;
    {psel, penable, pwrite, req, is_store, sum, en_xlate} = '0;
    paddr     = '0;
    pwdata    = '0;
    vaddr     = '0;
    priv      = PRIV_U;
    n_run     = 0;
    n_pass    = 0;
    n_fail    = 0;
    cycle_cnt = 0;
    // load every record, comment lines start with #
    fd = $fopen("bench/dmmu_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file bench/dmmu_testdata.txt");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt  = $fgets(line, fd);
        if (cnt > 0 && $sscanf(line, "%s", op) == 1 && op[0] != "#") recs.push_back(line);
      end
      $fclose(fd);
    end
    cycle_limit = 4 * recs.size() + 50;
    wait (rst_n === 1'b1);
    foreach (recs[i]) begin
      cnt = $sscanf(recs[i], "%s", op);
      if (op == "L") begin
        cnt = $sscanf(recs[i], "%s %h %h %h %h %h %h %h %h %h", op, f_req, f_en, f_store,
                      f_priv, f_sum, f_vaddr, e_valid, e_paddr, e_exc);
        if (cnt != 10) begin
          $display("test %0d: the lookup record is malformed", i);
          n_fail++;
        end else begin
          // back to back, check the previous slot then drive the next one
          @(negedge clk);
          if (q_id.size() > 0) check_pending();
          req      = f_req;
          en_xlate = f_en;
          is_store = f_store;
          priv     = priv_e'(f_priv);
          sum      = f_sum;
          vaddr    = f_vaddr;
          q_id.push_back(i);
          q_valid.push_back(e_valid);
          q_paddr.push_back(e_paddr);
          q_exc.push_back(e_exc);
        end
      end else if (op == "W" || op == "R") begin
        cnt = $sscanf(recs[i], "%s %h %h %h", op, f_addr, f_data, e_err);
        if (cnt != 4) begin
          $display("test %0d: the apb record is malformed", i);
          n_fail++;
        end else begin
          drain_lookups();
          apb_transfer(i, op == "W", f_addr[3:0], f_data, e_err);
        end
      end else begin
        $display("test %0d: unknown record type %s", i, op);
        n_fail++;
      end
    end
    drain_lookups();
    $display("summary: %0d tests run, %0d passed, %0d failed", n_run, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* bench/dmmu_testdata.txt */
# W addr data exp_pslverr | R addr exp_prdata exp_pslverr
# L req en store priv(0=U 1=S) sum vaddr exp_valid exp_paddr exp_exc(0 none 1 miss 2 ld 3 st)
L 1 0 0 1 0 7f12345678 1 12345678 0
L 0 0 0 1 0 0000001000 0 00000000 0
# entry 0 user 4k rwdu, entry 1 kernel 2m rwd, entry 2 user 1g rwu, entry 3 kernel 4k none
W 0 00000012 0
W 4 00080001 0
W 8 000000f0 0
W 0 00040600 0
W 4 000810ab 0
W 8 00000271 0
W 0 00080000 0
W 4 000c1234 0
W 8 000004b2 0
W 0 00000033 0
W 4 00000777 0
W 8 00000003 0
# translation, miss and access rights
L 1 1 0 0 0 0000012345 1 80001345 0
L 1 1 0 1 0 0040755abc 1 81155abc 0
L 1 1 0 0 0 00aabcd123 1 eabcd123 0
L 1 1 0 1 0 0000099000 1 00000000 1
L 1 1 0 1 0 0000012345 1 80001345 2
L 1 1 0 1 1 0000012345 1 80001345 0
L 1 1 1 1 0 0000012345 1 80001345 3
L 1 1 0 0 0 0040755abc 1 81155abc 2
L 1 1 1 1 0 0040755abc 1 81155abc 0
L 1 1 1 0 0 00aabcd123 1 eabcd123 3
L 1 1 0 1 0 0000033008 1 00777008 2
# entry 3 replaced, staged values read back
W 0 00000044 0
W 4 00000555 0
W 8 00000073 0
R 0 00000044 0
R 4 00000555 0
R 8 00000000 0
R c 00000000 0
L 1 1 0 1 0 0000033008 1 00000000 1
L 1 1 0 1 0 0000044fff 1 00555fff 0
# unmapped offsets leave the staging and the tlb alone
W 2 00000000 1
W 1 000000f3 1
R 6 00000000 1
R 0 00000044 0
L 1 1 0 1 0 0000044fff 1 00555fff 0
# flush, then index 0 written again with a new ppn
W c 00000000 0
L 1 1 0 0 0 0000012345 1 00000000 1
L 1 1 0 1 0 0000044fff 1 00000000 1
W 0 00000012 0
W 4 0009abcd 0
W 8 000000f0 0
L 1 1 0 0 0 0000012345 1 9abcd345 0

/* sources.f */
src/mmu_pkg.sv
src/tlb_apb_regs.sv
src/tlb_lookup.sv
src/xlate_check.sv
src/dmmu_top.sv
bench/tb_clock_gen.sv
bench/tb_dmmu.sv

/* Bender.yml */
package:
  name: dmmu

sources:
  - src/mmu_pkg.sv
  - src/tlb_apb_regs.sv
  - src/tlb_lookup.sv
  - src/xlate_check.sv
  - src/dmmu_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_dmmu.sv
